/* sim/hart_testdata.txt */
// @000 program words, @040 initial data words, @050 expected stores as test addr data
// @0FD program word count, @0FE data word count, @0FF expected store count
@000
// test 5: sw x2,0x100(x0); addi x0,x0,0x55; sw x0,0x104(x0)
10202023 05500013 10002223
// test 1: addi x5,0x123; addi x6,-5; lui x7,0x12345; xori x8,x5,0x0f0
12300293 FFB00313 123453B7 0F02C413
// slti x9,x6,-4; srai x10,x6,1; sub x11,x7,x5; sll x12,x5,x9
FFC32493 40135513 405385B3 00929633
// sra x13,x6,x9; srli x14,x6,28; slt x15,x6,x5; or x16,x7,x8; andi x17,x6,0x7f0
409356B3 01C35713 005327B3 0083E833 7F037893
// sw x7..x12 to 0x108..0x11c
10702423 10802623 10902823 10A02A23 10B02C23 10C02E23
// sw x13..x17 to 0x120..0x130
12D02023 12E02223 12F02423 13002623 13102823
// test 2: addi x20,7; slli x21,x20,3; add x22,x21,x20; xor x23,x22,x21
00700A13 003A1A93 014A8B33 015B4BB3
// ori x24,x23,0x500; and x25,x24,x22; srl x26,x24,x23
500BEC13 016C7CB3 017C5D33
// sw x26,0x134; sw x25,0x138; sw x22,0x13c
13A02A23 13902C23 13602E23
// test 3: lw x27,0(x0); add x28,x27,x21; lw x29,4(x0); sw x29,0x140(x0)
00002D83 015D8E33 00402E83 15D02023
// lw x30,8(x0); sub x31,x30,x29; sw x28,0x144(x0); sw x31,0x148(x0)
00802F03 41DF0FB3 15C02223 15F02423
@040
00001111 7FFF0000 000000FF
@050
05 00000100 0003F000
05 00000104 00000000
01 00000108 12345000
01 0000010C 000001D3
01 00000110 00000001
01 00000114 FFFFFFFD
01 00000118 12344EDD
01 0000011C 00000246
01 00000120 FFFFFFFD
01 00000124 0000000F
01 00000128 00000001
01 0000012C 123451D3
01 00000130 000007F0
02 00000134 0000000A
02 00000138 00000007
02 0000013C 0000003F
03 00000140 7FFF0000
03 00000144 00001149
03 00000148 800100FF
@0FD
0000002D
00000003
00000013

/* sim.f */
design/hart_pkg.sv
design/fetch_decode.sv
design/operand_stage.sv
design/execute_writeback.sv
design/hart_top.sv
sim/hart_checker.sv
sim/tb_hart.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run, pass only if the testbench reports it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_hart -f sim.f \
	&& ./obj_dir/Vtb_hart | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
	&& echo "run_sim: simulation passed" \
	|| { echo "run_sim: simulation failed"; exit 1; }

/* sim/tb_hart.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_hart;

	// word offsets inside the loaded testdata table
	localparam int data_base = 'h40;
	localparam int store_base = 'h50;
	localparam int prog_count_at = 'hFD;
	localparam int data_count_at = 'hFE;
	localparam int store_count_at = 'hFF;
	localparam int imem_words = 64;
	localparam int dmem_words = 256;
	// quiet cycles after the last store, catches late extra stores
	localparam int drain_cycles = 20;

	logic clock;
	logic reset;
	logic inst_req;
	logic [31:0] inst_addr;
	logic inst_done;
	logic [31:0] inst_data;
	logic data_req;
	logic data_wren;
	logic [31:0] data_addr;
	logic [31:0] data_wdata;
	logic data_done;
	logic [31:0] data_rdata;

	logic [31:0] tdata [0:255];
	logic [31:0] imem [0:imem_words-1];
	logic [31:0] dmem [0:dmem_words-1];
	logic [31:0] lcg_state;
	logic random_done;
	logic replay;
	int cycle_limit;
	int expected_tests;

	// checker results
	int seen;
	logic all_seen;
	int tests_run;
	int tests_failed;
	int errors;

	hart_top i_dut (
		.clock_i(clock),
		.reset_i(reset),
		.inst_req_o(inst_req),
		.inst_addr_o(inst_addr),
		.inst_done_i(inst_done),
		.inst_data_i(inst_data),
		.data_req_o(data_req),
		.data_wren_o(data_wren),
		.data_addr_o(data_addr),
		.data_data_o(data_wdata),
		.data_done_i(data_done),
		.data_data_i(data_rdata)
	);

	hart_checker i_checker (
		.clock_i(clock),
		.reset_i(reset),
		.replay_i(replay),
		.data_req_i(data_req),
		.data_wren_i(data_wren),
		.data_done_i(data_done),
		.data_addr_i(data_addr),
		.data_data_i(data_wdata),
		.table_i(tdata),
		.seen_o(seen),
		.all_seen_o(all_seen),
		.tests_run_o(tests_run),
		.tests_failed_o(tests_failed),
		.errors_o(errors)
	);

	// 20 ns period
	always #10 clock = ~clock;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// unknown opcode, so anything fetched past the program is a bubble
	function automatic logic [31:0] instr_fill(input logic [31:0] addr);
		return {addr[31:7] ^ addr[24:0], 7'h7F};
	endfunction

	function automatic logic [31:0] data_fill(input logic [31:0] addr);
		return addr ^ 32'hC3A5_5A3C;
	endfunction

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		if (addr[31:8] == '0) begin
			return imem[addr[7:2]];
		end
		return instr_fill(addr);
	endfunction

	// --------------------------------------------------
	// memory models
	// --------------------------------------------------
	// requests are taken at the edge, answers and done levels 1 ns later
	always @(posedge clock) begin : memory_model
		logic fetch_take;
		logic [31:0] fetch_addr;
		logic data_take;
		logic data_write;
		logic [31:0] addr_q;
		logic [31:0] wdata_q;
		fetch_take = inst_req && inst_done;
		fetch_addr = inst_addr;
		data_take = data_req && data_done;
		data_write = data_wren;
		addr_q = data_addr;
		wdata_q = data_wdata;
		#1;
		if (fetch_take) begin
			inst_data = fetch_word(fetch_addr);
		end
		if (data_take) begin
			if (data_write) begin
				dmem[addr_q[9:2]] = wdata_q;
			end else begin
				// held until the next accepted request
				data_rdata = dmem[addr_q[9:2]];
			end
		end
		// each done low one time in four under back-pressure
		if (random_done) begin
			lcg_state = lcg_next(lcg_state);
			inst_done = (lcg_state[31:30] != 2'b00);
			lcg_state = lcg_next(lcg_state);
			data_done = (lcg_state[31:30] != 2'b00);
		end else begin
			inst_done = 1'b1;
			data_done = 1'b1;
		end
	end

	task automatic load_memories();
		for (int i = 0; i < imem_words; i++) begin
			if (i < int'(tdata[prog_count_at])) begin
				imem[i] = tdata[i];
			end else begin
				imem[i] = instr_fill(32'(i) << 2);
			end
		end
		for (int i = 0; i < dmem_words; i++) begin
			if (i < int'(tdata[data_count_at])) begin
				dmem[i] = tdata[data_base + i];
			end else begin
				dmem[i] = data_fill(32'(i) << 2);
			end
		end
	endtask

	// reset, reload, then wait for the whole expected store list
	task automatic run_program(input logic with_backpressure);
		@(posedge clock);
		#1;
		reset = 1'b0;
		@(negedge clock);
		load_memories();
		random_done = with_backpressure;
		replay = with_backpressure;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b1;
		while (!all_seen) begin
			@(posedge clock);
		end
		repeat (drain_cycles) @(posedge clock);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin : main
		int n_stores;
		clock = 1'b0;
		reset = 1'b0;
		inst_done = 1'b1;
		data_done = 1'b1;
		inst_data = '0;
		data_rdata = '0;
		random_done = 1'b0;
		replay = 1'b0;
		lcg_state = 32'h3013_5064;
		cycle_limit = 0;
		for (int i = 0; i < 256; i++) begin
			tdata[i] = '0;
		end
		$readmemh("sim/hart_testdata.txt", tdata);
		n_stores = int'(tdata[store_count_at]);
		// one test per run of equal tags, plus the back-pressure replay
		expected_tests = 1;
		for (int i = 0; i < n_stores; i++) begin
			if (i == 0 || tdata[store_base + 3 * i] != tdata[store_base + 3 * (i - 1)]) begin
				expected_tests++;
			end
		end
		cycle_limit = 2 * (40 * int'(tdata[prog_count_at]) + 200);
		run_program(1'b0);
		run_program(1'b1);
		$display("summary: %0d of %0d tests run, %0d failed, %0d errors",
			tests_run, expected_tests, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && tests_run == expected_tests) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// both passes together, 40 cycles per program word plus slack
	initial begin : watchdog
		wait (cycle_limit > 0);
		repeat (cycle_limit) @(posedge clock);
		$display("timeout after %0d cycles, only %0d of %0d expected stores seen in this pass",
			cycle_limit, seen, int'(tdata[store_count_at]));
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/hart_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module hart_checker (
	input logic clock_i,
	input logic reset_i,
	// high while the program reruns under back-pressure
	input logic replay_i,
	input logic data_req_i,
	input logic data_wren_i,
	input logic data_done_i,
	input logic [31:0] data_addr_i,
	input logic [31:0] data_data_i,
	input logic [31:0] table_i [0:255],
	output int seen_o,
	output logic all_seen_o,
	output int tests_run_o,
	output int tests_failed_o,
	output int errors_o
);

	// expected stores are test, address, data triples
	localparam int store_base = 'h50;
	localparam int store_count_at = 'hFF;
	localparam int replay_test = 4;

	int idx;
	int n_err;
	int n_run;
	int n_fail;
	logic test_bad;

	initial begin
		idx = 0;
		n_err = 0;
		n_run = 0;
		n_fail = 0;
		test_bad = 1'b0;
		seen_o <= 0;
		all_seen_o <= 1'b0;
		tests_run_o <= 0;
		tests_failed_o <= 0;
		errors_o <= 0;
	end

	// --------------------------------------------------
	// store compare
	// --------------------------------------------------
	always @(posedge clock_i) begin : watch_stores
		int n_exp;
		int base;
		int tag;
		logic last;
		n_exp = int'(table_i[store_count_at]);
		if (!reset_i) begin
			idx = 0;
			test_bad = 1'b0;
		end else if (data_req_i && data_wren_i && data_done_i) begin
			if (idx >= n_exp) begin
				$display("%0t: extra store of %h to %h after all expected stores",
					$time, data_data_i, data_addr_i);
				n_err++;
			end else begin
				base = store_base + 3 * idx;
				if (data_addr_i != table_i[base + 1] || data_data_i != table_i[base + 2]) begin
					$display("[ERROR] %0t: store %0d expected %h at %h, observed %h at %h",
						$time, idx, table_i[base + 2], table_i[base + 1],
						data_data_i, data_addr_i);
					n_err++;
					test_bad = 1'b1;
				end
				tag = replay_i ? replay_test : int'(table_i[base]);
				// a test ends where its tag changes and the replay only at the very end
				last = (idx + 1 == n_exp)
					|| (!replay_i && table_i[base + 3] != table_i[base]);
				if (last) begin
					$display("%0t: test %0d %s", $time, tag, test_bad ? "failed" : "passed");
					n_run++;
					if (test_bad) begin
						n_fail++;
					end
					test_bad = 1'b0;
				end
				idx++;
			end
		end
		seen_o <= idx;
		all_seen_o <= (n_exp > 0) && (idx >= n_exp);
		tests_run_o <= n_run;
		tests_failed_o <= n_fail;
		errors_o <= n_err;
	end

endmodule

`default_nettype wire

/* design/hart_top.sv */
`timescale 1ns/10ps
`default_nettype none

module hart_top (
	input logic clock_i,
	input logic reset_i,
	// instruction port
	output logic inst_req_o,
	output logic [hart_pkg::xlen-1:0] inst_addr_o,
	input logic inst_done_i,
	input logic [hart_pkg::xlen-1:0] inst_data_i,
	// data port
	output logic data_req_o,
	output logic data_wren_o,
	output logic [hart_pkg::xlen-1:0] data_addr_o,
	output logic [hart_pkg::xlen-1:0] data_data_o,
	input logic data_done_i,
	input logic [hart_pkg::xlen-1:0] data_data_i
);

	import hart_pkg::*;

	logic advance;
	logic issue;
	// stage 2
	logic [enc_w-1:0] s2_enc;
	logic [reg_addr_w-1:0] s2_rd;
	logic [reg_addr_w-1:0] s2_rs1;
	logic [reg_addr_w-1:0] s2_rs2;
	logic [2:0] s2_funct3;
	logic s2_alt;
	logic [xlen-1:0] s2_imm;
	// stage 3
	logic [enc_w-1:0] ex_enc;
	logic [reg_addr_w-1:0] ex_rd;
	logic [2:0] ex_funct3;
	logic ex_alt;
	logic [xlen-1:0] ex_op_a;
	logic [xlen-1:0] ex_op_b;
	logic [xlen-1:0] ex_store;
	logic [xlen-1:0] ex_result;
	// stage 4
	logic wb_en;
	logic [reg_addr_w-1:0] wb_rd;
	logic [xlen-1:0] wb_value;

	// --------------------------------------------------
	// producer
	// --------------------------------------------------
	fetch_decode i_fetch_decode (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.issue_i(issue),
		.inst_data_i(inst_data_i),
		.inst_req_o(inst_req_o),
		.inst_addr_o(inst_addr_o),
		.enc_o(s2_enc),
		.rd_o(s2_rd),
		.rs1_o(s2_rs1),
		.rs2_o(s2_rs2),
		.funct3_o(s2_funct3),
		.alt_o(s2_alt),
		.imm_o(s2_imm)
	);

	// --------------------------------------------------
	// operands, hazards and control
	// --------------------------------------------------
	operand_stage i_operand_stage (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.inst_done_i(inst_done_i),
		.data_done_i(data_done_i),
		.enc_i(s2_enc),
		.rd_i(s2_rd),
		.rs1_i(s2_rs1),
		.rs2_i(s2_rs2),
		.funct3_i(s2_funct3),
		.alt_i(s2_alt),
		.imm_i(s2_imm),
		// stage 3 class and rd feed hazard detection and forwarding
		.ex_enc_i(ex_enc),
		.ex_rd_i(ex_rd),
		.ex_result_i(ex_result),
		.wb_en_i(wb_en),
		.wb_rd_i(wb_rd),
		.wb_value_i(wb_value),
		.advance_o(advance),
		.issue_o(issue),
		.ex_enc_o(ex_enc),
		.ex_rd_o(ex_rd),
		.ex_funct3_o(ex_funct3),
		.ex_alt_o(ex_alt),
		.ex_op_a_o(ex_op_a),
		.ex_op_b_o(ex_op_b),
		.ex_store_o(ex_store)
	);

	// --------------------------------------------------
	// consumer
	// --------------------------------------------------
	execute_writeback i_execute_writeback (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.advance_i(advance),
		.ex_enc_i(ex_enc),
		.ex_rd_i(ex_rd),
		.ex_funct3_i(ex_funct3),
		.ex_alt_i(ex_alt),
		.ex_op_a_i(ex_op_a),
		.ex_op_b_i(ex_op_b),
		.ex_store_i(ex_store),
		.data_data_i(data_data_i),
		.data_req_o(data_req_o),
		.data_wren_o(data_wren_o),
		.data_addr_o(data_addr_o),
		.data_data_o(data_data_o),
		.ex_result_o(ex_result),
		.wb_en_o(wb_en),
		.wb_rd_o(wb_rd),
		.wb_value_o(wb_value)
	);

endmodule

`default_nettype wire

/* design/execute_writeback.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_writeback (
	input logic clock_i,
	input logic reset_i,
	input logic advance_i,
	// stage 3 inputs
	input logic [hart_pkg::enc_w-1:0] ex_enc_i,
	input logic [hart_pkg::reg_addr_w-1:0] ex_rd_i,
	input logic [2:0] ex_funct3_i,
	input logic ex_alt_i,
	input logic [hart_pkg::xlen-1:0] ex_op_a_i,
	input logic [hart_pkg::xlen-1:0] ex_op_b_i,
	input logic [hart_pkg::xlen-1:0] ex_store_i,
	// data port
	input logic [hart_pkg::xlen-1:0] data_data_i,
	output logic data_req_o,
	output logic data_wren_o,
	output logic [hart_pkg::xlen-1:0] data_addr_o,
	output logic [hart_pkg::xlen-1:0] data_data_o,
	// back to operand stage
	output logic [hart_pkg::xlen-1:0] ex_result_o,
	output logic wb_en_o,
	output logic [hart_pkg::reg_addr_w-1:0] wb_rd_o,
	output logic [hart_pkg::xlen-1:0] wb_value_o
);

	import hart_pkg::*;

	logic [xlen-1:0] alu_result;
	logic [4:0] shamt;
	logic is_load;
	logic is_store;
	logic writes_rd;
	// stage 4 state
	logic wb_load_q;
	logic [xlen-1:0] wb_result_q;

	assign is_load = (ex_enc_i == enc_load);
	assign is_store = (ex_enc_i == enc_store);
	assign writes_rd = (ex_enc_i == enc_arith_imm) || (ex_enc_i == enc_arith_reg)
		|| (ex_enc_i == enc_lui) || is_load;
	assign shamt = ex_op_b_i[4:0];

	// --------------------------------------------------
	// alu
	// --------------------------------------------------
	always_comb begin
		alu_result = '0;
		if (ex_enc_i == enc_lui) begin
			// immediate arrives already shifted up
			alu_result = ex_op_b_i;
		end else if (is_load || is_store) begin
			// effective address
			alu_result = ex_op_a_i + ex_op_b_i;
		end else begin
			case (ex_funct3_i)
				f3_add: begin
					if (ex_alt_i) begin
						alu_result = ex_op_a_i - ex_op_b_i;
					end else begin
						alu_result = ex_op_a_i + ex_op_b_i;
					end
				end
				f3_sll: alu_result = ex_op_a_i << shamt;
				f3_slt: begin
					alu_result = {{(xlen-1){1'b0}}, $signed(ex_op_a_i) < $signed(ex_op_b_i)};
				end
				f3_xor: alu_result = ex_op_a_i ^ ex_op_b_i;
				f3_sr: begin
					// sra and srai fill with the sign bit
					if (ex_alt_i) begin
						alu_result = $signed(ex_op_a_i) >>> shamt;
					end else begin
						alu_result = ex_op_a_i >> shamt;
					end
				end
				f3_or: alu_result = ex_op_a_i | ex_op_b_i;
				f3_and: alu_result = ex_op_a_i & ex_op_b_i;
				default: alu_result = '0;
			endcase
		end
	end

	// forwarded only when stage 3 writes rd
	assign ex_result_o = alu_result;

	// --------------------------------------------------
	// data request
	// --------------------------------------------------
	// leaves while the instruction is in stage 3 and only in an advancing
	// cycle so a frozen store is never accepted twice
	assign data_req_o = advance_i && (is_load || is_store);
	assign data_wren_o = advance_i && is_store;
	assign data_addr_o = alu_result;
	assign data_data_o = ex_store_i;

	// --------------------------------------------------
	// stage 4 register and writeback
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			wb_en_o <= 1'b0;
			wb_load_q <= 1'b0;
		end else if (advance_i) begin
			// x0 is never written
			wb_en_o <= writes_rd && (ex_rd_i != '0);
			wb_load_q <= is_load;
			wb_rd_o <= ex_rd_i;
			wb_result_q <= alu_result;
		end
	end

	// load word shows up the cycle after the request and is held by the memory
	assign wb_value_o = wb_load_q ? data_data_i : wb_result_q;

	// only word accesses exist so every data address is word aligned
	assert property (@(posedge clock_i) disable iff (!reset_i)
		data_req_o |-> (data_addr_o[1:0] == 2'b00));

endmodule

`default_nettype wire

/* design/operand_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_stage (
	input logic clock_i,
	input logic reset_i,
	input logic inst_done_i,
	input logic data_done_i,
	// stage 2 fields
	input logic [hart_pkg::enc_w-1:0] enc_i,
	input logic [hart_pkg::reg_addr_w-1:0] rd_i,
	input logic [hart_pkg::reg_addr_w-1:0] rs1_i,
	input logic [hart_pkg::reg_addr_w-1:0] rs2_i,
	input logic [2:0] funct3_i,
	input logic alt_i,
	input logic [hart_pkg::xlen-1:0] imm_i,
	// stage 3 and stage 4 feedback
	input logic [hart_pkg::enc_w-1:0] ex_enc_i,
	input logic [hart_pkg::reg_addr_w-1:0] ex_rd_i,
	input logic [hart_pkg::xlen-1:0] ex_result_i,
	input logic wb_en_i,
	input logic [hart_pkg::reg_addr_w-1:0] wb_rd_i,
	input logic [hart_pkg::xlen-1:0] wb_value_i,
	output logic advance_o,
	output logic issue_o,
	output logic [hart_pkg::enc_w-1:0] ex_enc_o,
	output logic [hart_pkg::reg_addr_w-1:0] ex_rd_o,
	output logic [2:0] ex_funct3_o,
	output logic ex_alt_o,
	output logic [hart_pkg::xlen-1:0] ex_op_a_o,
	output logic [hart_pkg::xlen-1:0] ex_op_b_o,
	output logic [hart_pkg::xlen-1:0] ex_store_o
);

	import hart_pkg::*;

	logic [xlen-1:0] rf [0:(1 << reg_addr_w)-1];
	logic ex_writes;
	logic ex_is_load;
	logic uses_rs1;
	logic uses_rs2;
	logic hazard;
	logic bubble;
	logic [xlen-1:0] rs1_val;
	logic [xlen-1:0] rs2_val;

	// --------------------------------------------------
	// pipeline control
	// --------------------------------------------------
	// whole pipeline freezes while either memory is busy
	assign advance_o = inst_done_i && data_done_i;

	assign ex_writes = (ex_enc_i == enc_arith_imm) || (ex_enc_i == enc_arith_reg)
		|| (ex_enc_i == enc_lui);
	assign ex_is_load = (ex_enc_i == enc_load);

	// which source fields the stage 2 instruction really reads
	assign uses_rs1 = (enc_i == enc_arith_imm) || (enc_i == enc_arith_reg)
		|| (enc_i == enc_load) || (enc_i == enc_store);
	assign uses_rs2 = (enc_i == enc_arith_reg) || (enc_i == enc_store);

	// load in stage 3 has no value yet so wait one cycle for the writeback path
	assign hazard = ex_is_load && (ex_rd_i != '0)
		&& ((uses_rs1 && (rs1_i == ex_rd_i)) || (uses_rs2 && (rs2_i == ex_rd_i)));

	assign issue_o = advance_o && !hazard;
	assign bubble = advance_o && hazard;

	// --------------------------------------------------
	// register file
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			for (int i = 0; i < (1 << reg_addr_w); i++) begin
				rf[i] <= (i == int'(sp_reg)) ? sp_base : '0;
			end
		end else if (advance_o && wb_en_i && (wb_rd_i != '0)) begin
			rf[wb_rd_i] <= wb_value_i;
		end
	end

	// x0 first, then stage 3, then writeback, then the array
	function automatic logic [xlen-1:0] pick_operand(input logic [reg_addr_w-1:0] idx);
		if (idx == '0) begin
			return '0;
		end
		if (ex_writes && (ex_rd_i == idx)) begin
			return ex_result_i;
		end
		if (wb_en_i && (wb_rd_i == idx)) begin
			return wb_value_i;
		end
		return rf[idx];
	endfunction

	always_comb begin
		rs1_val = pick_operand(rs1_i);
		rs2_val = pick_operand(rs2_i);
	end

	// --------------------------------------------------
	// stage 3 register
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			ex_enc_o <= enc_none;
		end else if (advance_o) begin
			// stalled instruction stays in stage 2 while stage 3 gets a bubble
			ex_enc_o <= bubble ? enc_none : enc_i;
			ex_rd_o <= rd_i;
			ex_funct3_o <= funct3_i;
			ex_alt_o <= alt_i;
			ex_op_a_o <= rs1_val;
			// loads and stores add the immediate too
			ex_op_b_o <= (enc_i == enc_arith_reg) ? rs2_val : imm_i;
			ex_store_o <= rs2_val;
		end
	end

	// the inserted bubble clears the hazard so a load-use stall never repeats
	assert property (@(posedge clock_i) disable iff (!reset_i) bubble |=> !hazard);

endmodule

`default_nettype wire

/* design/fetch_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_decode (
	input logic clock_i,
	input logic reset_i,
	input logic issue_i,
	input logic [hart_pkg::xlen-1:0] inst_data_i,
	output logic inst_req_o,
	output logic [hart_pkg::xlen-1:0] inst_addr_o,
	output logic [hart_pkg::enc_w-1:0] enc_o,
	output logic [hart_pkg::reg_addr_w-1:0] rd_o,
	output logic [hart_pkg::reg_addr_w-1:0] rs1_o,
	output logic [hart_pkg::reg_addr_w-1:0] rs2_o,
	output logic [2:0] funct3_o,
	output logic alt_o,
	output logic [hart_pkg::xlen-1:0] imm_o
);

	import hart_pkg::*;

	// high once a fetched word sits on inst_data_i
	logic word_valid_q;
	instr_t word;
	logic f3_ok;
	logic [enc_w-1:0] dec_enc;
	logic [xlen-1:0] dec_imm;
	logic dec_alt;

	// --------------------------------------------------
	// fetch
	// --------------------------------------------------
	// a request is only offered in a cycle that also consumes the returned word,
	// so the memory never moves past a word the decode register still needs
	assign inst_req_o = issue_i;

	// pc is the address on the port and steps once per accepted request
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			inst_addr_o <= reset_pc;
			word_valid_q <= 1'b0;
		end else if (issue_i) begin
			inst_addr_o <= inst_addr_o + 32'd4;
			word_valid_q <= 1'b1;
		end
	end

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	// memory holds the word until the next accepted request
	assign word = inst_data_i;

	// sltu and sltiu are not supported
	assign f3_ok = word.r.funct3 inside {f3_add, f3_sll, f3_slt, f3_xor, f3_sr, f3_or, f3_and};

	always_comb begin
		dec_enc = enc_none;
		dec_alt = 1'b0;
		// i-type immediate by default
		dec_imm = {{(xlen-12){word.i.imm_hi[11]}}, word.i.imm_hi};
		case (word.r.opcode)
			op_arith_imm: begin
				if (f3_ok) begin
					dec_enc = enc_arith_imm;
					// only srai carries funct7 so addi never subtracts
					dec_alt = (word.r.funct3 == f3_sr) && (word.r.funct7 == f7_alt);
				end
			end
			op_arith_reg: begin
				if (f3_ok) begin
					dec_enc = enc_arith_reg;
					dec_alt = (word.r.funct7 == f7_alt);
				end
			end
			op_lui: begin
				dec_enc = enc_lui;
				// upper 20 bits span imm_hi, rs1 and funct3
				dec_imm = {word.i.imm_hi, word.i.rs1, word.i.funct3, 12'b0};
			end
			op_load: begin
				if (word.i.funct3 == f3_word) begin
					dec_enc = enc_load;
				end
			end
			op_store: begin
				if (word.i.funct3 == f3_word) begin
					dec_enc = enc_store;
					// s-type low five bits live in the rd slot
					dec_imm = {{(xlen-12){word.i.imm_hi[11]}}, word.i.imm_hi[11:5], word.i.rd};
				end
			end
			// unknown opcode becomes a bubble
			default: dec_enc = enc_none;
		endcase
	end

	// stage 2 register holds through stalls and freezes
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			enc_o <= enc_none;
		end else if (issue_i) begin
			// nothing fetched yet right after reset
			enc_o <= word_valid_q ? dec_enc : enc_none;
			rd_o <= word.r.rd;
			rs1_o <= word.r.rs1;
			rs2_o <= word.r.rs2;
			funct3_o <= word.r.funct3;
			alt_o <= dec_alt;
			imm_o <= dec_imm;
		end
	end

	// decode reads the port directly so the word must not move without a request
	assert property (@(posedge clock_i) disable iff (!reset_i)
		!issue_i |=> $stable(inst_data_i));

endmodule

`default_nettype wire

/* design/hart_pkg.sv */
`default_nettype none

package hart_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam int enc_w = 6;

	// one-hot instruction class, zero is a bubble
	localparam logic [enc_w-1:0] enc_none = 6'b000000;
	localparam logic [enc_w-1:0] enc_arith_imm = 6'b000001;
	localparam logic [enc_w-1:0] enc_arith_reg = 6'b000010;
	localparam logic [enc_w-1:0] enc_lui = 6'b000100;
	localparam logic [enc_w-1:0] enc_load = 6'b001000;
	localparam logic [enc_w-1:0] enc_store = 6'b010000;

	// --------------------------------------------------
	// rv32i opcode and function fields
	// --------------------------------------------------
	localparam logic [6:0] op_arith_imm = 7'b0010011;
	localparam logic [6:0] op_arith_reg = 7'b0110011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_sr = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	// lw and sw share this one
	localparam logic [2:0] f3_word = 3'b010;

	// sub and sra select
	localparam logic [6:0] f7_alt = 7'b0100000;

	// reset values
	localparam logic [xlen-1:0] sp_base = 32'h0003_F000;
	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
	localparam logic [reg_addr_w-1:0] sp_reg = 5'd2;

	// instruction word, register layout and immediate layout
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [reg_addr_w-1:0] rs2;
			logic [reg_addr_w-1:0] rs1;
			logic [2:0] funct3;
			logic [reg_addr_w-1:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm_hi;
			logic [reg_addr_w-1:0] rs1;
			logic [2:0] funct3;
			logic [reg_addr_w-1:0] rd;
			logic [6:0] opcode;
		} i;
	} instr_t;

endpackage

`default_nettype wire
